// ==== flist.f ====
src/mem_bench_pkg.sv
src/bench_cmd_decoder.sv
src/mem_access_generator.sv
src/bench_result_collector.sv
src/mem_bench_top.sv
sim/mem_bench_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory benchmark testbench

VERILATOR ?= verilator
TOP       ?= mem_bench_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result line, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation clean"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/mem_bench_tb.sv ====
`timescale 1ns/1ps

module mem_bench_tb;

   localparam int NUM_CH       = mem_bench_pkg::NUM_CHANNELS;
   localparam int NUM_RUNS     = 6;
   localparam int MAX_ACCESSES = 48;
   localparam int MAX_DELAY    = 12;                 // status latency bound in cycles
   localparam int CYCLE_LIMIT  = NUM_RUNS * MAX_ACCESSES * (MAX_DELAY + 8) + 500;

   logic                       user_clk;
   logic                       user_aresetn    = 1'b0;
   logic                       cmd_valid       = 1'b0;
   mem_bench_pkg::bench_cmd_t  cmd             = '0;
   mem_bench_pkg::chan_idx_t   cmd_dest        = '0;
   logic                       cmd_ready;
   logic [NUM_CH-1:0]          rd_req_valid;
   mem_bench_pkg::mem_req_t    rd_req [NUM_CH];
   logic [NUM_CH-1:0]          rd_req_ready    = '0;
   logic [NUM_CH-1:0]          wr_req_valid;
   mem_bench_pkg::mem_req_t    wr_req [NUM_CH];
   logic [NUM_CH-1:0]          wr_req_ready    = '0;
   logic [NUM_CH-1:0]          rd_status_valid = '0;
   logic [NUM_CH-1:0]          wr_status_valid = '0;
   logic                       bench_busy;
   mem_bench_pkg::cycles_t     exec_cycles;
   logic                       exec_cycles_valid;

   mem_bench_pkg::mem_req_t    exp_reqs [NUM_RUNS*MAX_ACCESSES];
   int                         exp_total       = 0;   // requests the model expects so far
   int                         taken           = 0;   // requests the memory accepted so far
   int                         due_q [$];             // cycles at which status goes out
   int                         last_due        = 0;
   int                         status_seen     = 0;
   int                         status_target   = 0;
   int                         final_cyc       = 0;   // edge that sampled the last status
   int                         cyc             = 0;
   int                         ready_pct       = 100;
   logic                       run_active      = 1'b0;
   int                         run_ch          = 0;
   logic                       run_write       = 1'b0;
   int                         wrap_count      = 0;
   int                         errors          = 0;
   int                         errors_at_start = 0;
   int                         tests_run       = 0;
   int                         tests_failed    = 0;

   mem_bench_top mem_bench_top_inst (
      .user_clk          (user_clk),
      .user_aresetn      (user_aresetn),
      .cmd_valid         (cmd_valid),
      .cmd               (cmd),
      .cmd_dest          (cmd_dest),
      .cmd_ready         (cmd_ready),
      .rd_req_valid      (rd_req_valid),
      .rd_req            (rd_req),
      .rd_req_ready      (rd_req_ready),
      .wr_req_valid      (wr_req_valid),
      .wr_req            (wr_req),
      .wr_req_ready      (wr_req_ready),
      .rd_status_valid   (rd_status_valid),
      .wr_status_valid   (wr_status_valid),
      .bench_busy        (bench_busy),
      .exec_cycles       (exec_cycles),
      .exec_cycles_valid (exec_cycles_valid)
   );

   initial begin
      user_clk = 1'b0;
      forever #5 user_clk = ~user_clk;
   end

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      if (exp !== act) begin
         $display("mismatch at %0t: %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic report_failure(input string what);
      $display("error at %0t: %s", $time, what);
      errors++;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == errors_at_start) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: FAILED with %0d errors", tests_run, name,
                  errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   function automatic int rand_range(input int lo, input int hi);
      int unsigned span;
      span = hi - lo + 1;
      return lo + int'($urandom % span);
   endfunction

   function automatic mem_bench_pkg::bench_cmd_t random_cmd(input logic is_write,
                                                            input int   max_acc);
      mem_bench_pkg::bench_cmd_t c;
      logic [63:0]               r64;
      r64            = {$urandom, $urandom};
      c.base_addr    = mem_bench_pkg::addr_t'(r64) & ~mem_bench_pkg::addr_t'(63);
      c.mem_size     = mem_bench_pkg::addr_t'(1024 * rand_range(1, 16));
      c.num_accesses = mem_bench_pkg::len_t'(rand_range(4, max_acc));
      c.chunk_len    = mem_bench_pkg::len_t'(64 * rand_range(1, 8));
      c.stride       = mem_bench_pkg::len_t'(64 * rand_range(1, 16));
      c.is_write     = is_write;
      return c;
   endfunction

   // accepts one request and schedules its status strobe in order after a random delay
   task automatic take_request(input int ch, input mem_bench_pkg::mem_req_t got);
      mem_bench_pkg::mem_req_t want;
      int                      due;
      if (taken >= exp_total) begin
         report_failure($sformatf("channel %0d issued more requests than commanded", ch));
      end else begin
         want = exp_reqs[taken];
         taken++;
         check_value($sformatf("ch%0d req.addr", ch), 64'(want.addr), 64'(got.addr));
         check_value($sformatf("ch%0d req.len", ch), 64'(want.len), 64'(got.len));
         due = cyc + rand_range(0, MAX_DELAY - 1);
         if (due <= last_due) begin
            due = last_due + 1;                   // one strobe per cycle
         end
         last_due = due;
         due_q.push_back(due);
      end
   endtask

   // starts right after a rising edge and ends on one
   task automatic run_bench(input int ch, input mem_bench_pkg::bench_cmd_t c);
      logic [63:0]            off;
      logic [63:0]            nxt;
      int                     accept_cyc;
      mem_bench_pkg::cycles_t held;
      wrap_count = 0;
      off        = '0;
      for (int i = 0; i < int'(c.num_accesses); i++) begin
         if (i > 0 && off == '0) begin
            wrap_count++;
         end
         exp_reqs[exp_total].addr = c.base_addr + mem_bench_pkg::addr_t'(off);
         exp_reqs[exp_total].len  = c.chunk_len;
         exp_total++;
         nxt = off + 64'(c.stride);
         if (nxt + 64'(c.chunk_len) > 64'(c.mem_size)) begin
            nxt = '0;                             // next chunk would overrun the region
         end
         off = nxt;
      end
      status_target = status_seen + int'(c.num_accesses);
      run_ch        = ch;
      run_write     = c.is_write;
      run_active    = 1'b1;
      cmd_valid <= 1'b1;
      cmd       <= c;
      cmd_dest  <= mem_bench_pkg::chan_idx_t'(ch);
      do begin
         @(posedge user_clk);
      end while (!cmd_ready);
      accept_cyc = cyc;
      cmd_valid <= 1'b0;
      @(posedge user_clk);
      while (!exec_cycles_valid) begin
         check_value("bench_busy", 64'd1, 64'(bench_busy));
         @(posedge user_clk);
      end
      held = mem_bench_pkg::cycles_t'(final_cyc - accept_cyc);
      check_value("bench_busy", 64'd0, 64'(bench_busy));
      check_value("exec_cycles", held, exec_cycles);
      check_value("requests taken", 64'(exp_total), 64'(taken));
      check_value("status strobes", 64'(status_target), 64'(status_seen));
      run_active = 1'b0;
      repeat (rand_range(3, 10)) begin
         @(posedge user_clk);
         check_value("exec_cycles_valid", 64'd0, 64'(exec_cycles_valid));
         check_value("bench_busy", 64'd0, 64'(bench_busy));
         check_value("exec_cycles", held, exec_cycles);
      end
   endtask

   // memory responder and request monitor
   always @(posedge user_clk) begin
      logic rd_ok;
      logic wr_ok;
      cyc <= cyc + 1;
      if (cyc >= CYCLE_LIMIT) begin
         $display("timeout: no benchmark result after %0d cycles", CYCLE_LIMIT);
         $display("Testbench failed");
         $finish;
      end else if (!user_aresetn) begin
         rd_req_ready    <= '0;
         wr_req_ready    <= '0;
         rd_status_valid <= '0;
         wr_status_valid <= '0;
      end else begin
         for (int ch = 0; ch < NUM_CH; ch++) begin
            rd_ok = run_active && (ch == run_ch) && !run_write;
            wr_ok = run_active && (ch == run_ch) && run_write;
            if (rd_req_valid[ch] && !rd_ok) begin
               report_failure($sformatf("read request on idle channel %0d", ch));
            end else if (rd_req_valid[ch] && rd_req_ready[ch]) begin
               take_request(ch, rd_req[ch]);
            end
            if (wr_req_valid[ch] && !wr_ok) begin
               report_failure($sformatf("write request on idle channel %0d", ch));
            end else if (wr_req_valid[ch] && wr_req_ready[ch]) begin
               take_request(ch, wr_req[ch]);
            end
            if (rd_status_valid[ch] || wr_status_valid[ch]) begin
               status_seen++;
               if (status_seen == status_target) begin
                  final_cyc = cyc;                // DUT samples its last status here
               end
            end
            rd_req_ready[ch] <= rand_range(0, 99) < ready_pct;
            wr_req_ready[ch] <= rand_range(0, 99) < ready_pct;
         end
         rd_status_valid <= '0;
         wr_status_valid <= '0;
         if (due_q.size() > 0 && due_q[0] <= cyc) begin
            void'(due_q.pop_front());
            if (run_write) begin
               wr_status_valid[run_ch] <= 1'b1;
            end else begin
               rd_status_valid[run_ch] <= 1'b1;
            end
         end
      end
   end

   initial begin
      mem_bench_pkg::bench_cmd_t c;
      void'($urandom(56));
      repeat (4) @(posedge user_clk);
      check_value("cmd_ready", 64'd0, 64'(cmd_ready));
      check_value("rd_req_valid", 64'd0, 64'(rd_req_valid));
      check_value("wr_req_valid", 64'd0, 64'(wr_req_valid));
      check_value("bench_busy", 64'd0, 64'(bench_busy));
      check_value("exec_cycles_valid", 64'd0, 64'(exec_cycles_valid));
      user_aresetn <= 1'b1;
      @(posedge user_clk);
      check_value("cmd_ready", 64'd0, 64'(cmd_ready));
      @(posedge user_clk);
      check_value("cmd_ready", 64'd1, 64'(cmd_ready));
      end_test("reset");

      ready_pct = 80;
      run_bench(0, random_cmd(1'b0, 32));
      end_test("read on channel 0");

      run_bench(NUM_CH - 1, random_cmd(1'b1, 32));
      end_test($sformatf("write on channel %0d", NUM_CH - 1));

      c              = random_cmd(rand_range(0, 1) == 1, 16);
      c.mem_size     = 48'd1024;
      c.chunk_len    = 32'd128;
      c.stride       = 32'd384;                   // three chunks fit before offset zero again
      c.num_accesses = 32'd16;
      run_bench(rand_range(0, NUM_CH - 1), c);
      end_test($sformatf("wrap, %0d returns to offset zero", wrap_count));

      ready_pct = 35;
      run_bench(rand_range(0, NUM_CH - 1), random_cmd(rand_range(0, 1) == 1, MAX_ACCESSES));
      end_test("random back-pressure");

      ready_pct = 70;
      run_bench(0, random_cmd(rand_range(0, 1) == 1, 32));
      run_bench(NUM_CH - 1, random_cmd(rand_range(0, 1) == 1, 32));
      end_test("busy flag and held result");

      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== src/mem_bench_top.sv ====
`timescale 1ns/1ps

module mem_bench_top (
   input  logic                                    user_clk,
   input  logic                                    user_aresetn,

   // benchmark command
   input  logic                                    cmd_valid,
   input  mem_bench_pkg::bench_cmd_t               cmd,
   input  mem_bench_pkg::chan_idx_t                cmd_dest,
   output logic                                    cmd_ready,

   // memory ports, one entry per channel
   output logic [mem_bench_pkg::NUM_CHANNELS-1:0]  rd_req_valid,
   output mem_bench_pkg::mem_req_t                 rd_req [mem_bench_pkg::NUM_CHANNELS],
   input  logic [mem_bench_pkg::NUM_CHANNELS-1:0]  rd_req_ready,
   output logic [mem_bench_pkg::NUM_CHANNELS-1:0]  wr_req_valid,
   output mem_bench_pkg::mem_req_t                 wr_req [mem_bench_pkg::NUM_CHANNELS],
   input  logic [mem_bench_pkg::NUM_CHANNELS-1:0]  wr_req_ready,
   input  logic [mem_bench_pkg::NUM_CHANNELS-1:0]  rd_status_valid,
   input  logic [mem_bench_pkg::NUM_CHANNELS-1:0]  wr_status_valid,

   // result
   output logic                                    bench_busy,
   output mem_bench_pkg::cycles_t                  exec_cycles,
   output logic                                    exec_cycles_valid
);

   mem_bench_pkg::bench_cmd_t               params;
   logic [mem_bench_pkg::NUM_CHANNELS-1:0]  start;
   logic                                    cmd_accept;
   logic [mem_bench_pkg::NUM_CHANNELS-1:0]  done_valid;
   mem_bench_pkg::cycles_t                  done_cycles [mem_bench_pkg::NUM_CHANNELS];

   bench_cmd_decoder bench_cmd_decoder_inst (
      .user_clk     (user_clk),
      .user_aresetn (user_aresetn),
      .cmd_valid    (cmd_valid),
      .cmd          (cmd),
      .cmd_dest     (cmd_dest),
      .cmd_ready    (cmd_ready),
      .params       (params),
      .start        (start),
      .cmd_accept   (cmd_accept)
   );

   for (genvar ch = 0; ch < mem_bench_pkg::NUM_CHANNELS; ch++) begin : g_chan
      mem_access_generator mem_access_generator_inst (
         .user_clk        (user_clk),
         .user_aresetn    (user_aresetn),
         .start           (start[ch]),
         .params          (params),
         .rd_req_valid    (rd_req_valid[ch]),
         .rd_req          (rd_req[ch]),
         .rd_req_ready    (rd_req_ready[ch]),
         .wr_req_valid    (wr_req_valid[ch]),
         .wr_req          (wr_req[ch]),
         .wr_req_ready    (wr_req_ready[ch]),
         .rd_status_valid (rd_status_valid[ch]),
         .wr_status_valid (wr_status_valid[ch]),
         .done_valid      (done_valid[ch]),
         .done_cycles     (done_cycles[ch])
      );
   end

   bench_result_collector bench_result_collector_inst (
      .user_clk          (user_clk),
      .user_aresetn      (user_aresetn),
      .cmd_accept        (cmd_accept),
      .done_valid        (done_valid),
      .done_cycles       (done_cycles),
      .bench_busy        (bench_busy),
      .exec_cycles       (exec_cycles),
      .exec_cycles_valid (exec_cycles_valid)
   );

endmodule

// ==== src/bench_result_collector.sv ====
`timescale 1ns/1ps

module bench_result_collector (
   input  logic                                    user_clk,
   input  logic                                    user_aresetn,
   input  logic                                    cmd_accept,
   input  logic [mem_bench_pkg::NUM_CHANNELS-1:0]  done_valid,
   input  mem_bench_pkg::cycles_t                  done_cycles [mem_bench_pkg::NUM_CHANNELS],
   output logic                                    bench_busy,
   output mem_bench_pkg::cycles_t                  exec_cycles,
   output logic                                    exec_cycles_valid
);

   mem_bench_pkg::cycles_t sel_cycles;
   logic                   any_done;
   logic                   running;

   assign any_done = |done_valid;

   // later channels override earlier ones on a tie
   always_comb begin
      sel_cycles = '0;
      for (int ch = 0; ch < mem_bench_pkg::NUM_CHANNELS; ch++) begin
         if (done_valid[ch]) begin
            sel_cycles = done_cycles[ch];
         end
      end
   end

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         running           <= 1'b0;
         exec_cycles       <= '0;
         exec_cycles_valid <= 1'b0;
      end else begin
         exec_cycles_valid <= any_done;
         if (any_done) begin
            exec_cycles <= sel_cycles;        // held until the next run reports
         end
         if (cmd_accept) begin
            running <= 1'b1;                  // a new run wins over a finishing one
         end else if (any_done) begin
            running <= 1'b0;
         end
      end
   end

   // busy from the accept pulse on, low again together with the result strobe
   assign bench_busy = cmd_accept || running;

endmodule

// ==== src/mem_access_generator.sv ====
`timescale 1ns/1ps

module mem_access_generator (
   input  logic                       user_clk,
   input  logic                       user_aresetn,
   input  logic                       start,
   input  mem_bench_pkg::bench_cmd_t  params,
   output logic                       rd_req_valid,
   output mem_bench_pkg::mem_req_t    rd_req,
   input  logic                       rd_req_ready,
   output logic                       wr_req_valid,
   output mem_bench_pkg::mem_req_t    wr_req,
   input  logic                       wr_req_ready,
   input  logic                       rd_status_valid,
   input  logic                       wr_status_valid,
   output logic                       done_valid,
   output mem_bench_pkg::cycles_t     done_cycles
);

   mem_bench_pkg::gen_state_t  state;
   mem_bench_pkg::bench_cmd_t  cfg;          // run parameters, latched on start
   mem_bench_pkg::mem_req_t    req;          // request currently offered
   logic                       req_valid;
   mem_bench_pkg::addr_t       offset;       // offset of the offered request
   mem_bench_pkg::addr_t       stepped;
   mem_bench_pkg::addr_t       next_offset;
   mem_bench_pkg::len_t        issued;       // requests transferred
   mem_bench_pkg::len_t        completed;    // status strobes seen
   mem_bench_pkg::cycles_t     cycle_cnt;    // edges since the accepting edge
   logic                       launch;
   logic                       req_fire;
   logic                       status_hit;
   logic                       last_issue;
   logic                       last_status;

   assign launch      = (state == mem_bench_pkg::IDLE) && start;
   assign req_fire    = req_valid && (cfg.is_write ? wr_req_ready : rd_req_ready);
   assign status_hit  = cfg.is_write ? wr_status_valid : rd_status_valid;
   assign last_issue  = (state == mem_bench_pkg::ISSUE) && req_fire &&
                        (issued + 1'b1 == cfg.num_accesses);
   assign last_status = (state == mem_bench_pkg::DRAIN) && status_hit &&
                        (completed + 1'b1 == cfg.num_accesses);

   // step by stride, back to zero once the next chunk would overrun the region
   always_comb begin
      stepped = offset + mem_bench_pkg::addr_t'(cfg.stride);
      if (stepped + mem_bench_pkg::addr_t'(cfg.chunk_len) > cfg.mem_size) begin
         next_offset = '0;
      end else begin
         next_offset = stepped;
      end
   end

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         state      <= mem_bench_pkg::IDLE;
         req_valid  <= 1'b0;
         done_valid <= 1'b0;
         issued     <= '0;
         completed  <= '0;
         cycle_cnt  <= '0;
      end else begin
         done_valid <= last_status;
         case (state)
            mem_bench_pkg::IDLE: begin
               if (start) begin
                  req_valid <= 1'b1;
                  issued    <= '0;
                  completed <= '0;
                  cycle_cnt <= mem_bench_pkg::cycles_t'(1);   // this edge counts already
                  state     <= mem_bench_pkg::ISSUE;
               end
            end
            mem_bench_pkg::ISSUE: begin
               cycle_cnt <= cycle_cnt + 1'b1;
               if (status_hit) begin
                  completed <= completed + 1'b1;              // early answers count too
               end
               if (req_fire) begin
                  issued <= issued + 1'b1;
               end
               if (last_issue) begin
                  req_valid <= 1'b0;
                  state     <= mem_bench_pkg::DRAIN;
               end
            end
            mem_bench_pkg::DRAIN: begin
               cycle_cnt <= cycle_cnt + 1'b1;
               if (status_hit) begin
                  completed <= completed + 1'b1;
               end
               if (last_status) begin
                  state <= mem_bench_pkg::IDLE;
               end
            end
            default: begin
               state     <= mem_bench_pkg::IDLE;
               req_valid <= 1'b0;
            end
         endcase
      end
   end

   // request payload and result, only written when they change meaning
   always_ff @(posedge user_clk) begin
      if (launch) begin
         cfg      <= params;
         offset   <= '0;
         req.addr <= params.base_addr;
         req.len  <= params.chunk_len;
      end else if (req_fire && !last_issue) begin
         offset   <= next_offset;
         req.addr <= cfg.base_addr + next_offset;
      end
      if (last_status) begin
         done_cycles <= cycle_cnt + 1'b1;                     // includes the final edge
      end
   end

   // only the selected port carries traffic
   assign rd_req_valid = req_valid && !cfg.is_write;
   assign wr_req_valid = req_valid && cfg.is_write;
   assign rd_req       = rd_req_valid ? req : '0;
   assign wr_req       = wr_req_valid ? req : '0;

   // a stalled request must hold until the memory takes it
   a_rd_hold: assert property (@(posedge user_clk) disable iff (!user_aresetn)
      rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req));
   a_wr_hold: assert property (@(posedge user_clk) disable iff (!user_aresetn)
      wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req));

   // memory answers only requests of a run in flight
   a_no_idle_status: assert property (@(posedge user_clk) disable iff (!user_aresetn)
      state == mem_bench_pkg::IDLE |-> !(rd_status_valid || wr_status_valid));

endmodule

// ==== src/bench_cmd_decoder.sv ====
`timescale 1ns/1ps

module bench_cmd_decoder (
   input  logic                                    user_clk,
   input  logic                                    user_aresetn,
   input  logic                                    cmd_valid,
   input  mem_bench_pkg::bench_cmd_t               cmd,
   input  mem_bench_pkg::chan_idx_t                cmd_dest,
   output logic                                    cmd_ready,
   output mem_bench_pkg::bench_cmd_t               params,
   output logic [mem_bench_pkg::NUM_CHANNELS-1:0]  start,
   output logic                                    cmd_accept
);

   logic accept;

   assign accept = cmd_valid && cmd_ready;

   // ready comes up one cycle out of reset and stays there
   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         cmd_ready  <= 1'b0;
         start      <= '0;
         cmd_accept <= 1'b0;
      end else begin
         cmd_ready  <= 1'b1;
         cmd_accept <= accept;                       // tells the collector a run began
         for (int ch = 0; ch < mem_bench_pkg::NUM_CHANNELS; ch++) begin
            start[ch] <= accept && (cmd_dest == mem_bench_pkg::chan_idx_t'(ch));
         end
      end
   end

   // parameters shared by every channel, sampled on acceptance only
   always_ff @(posedge user_clk) begin
      if (accept) begin
         params <= cmd;
      end
   end

   // a zero count, chunk or region would leave a channel with nothing to do
   a_cmd_sane: assert property (@(posedge user_clk) disable iff (!user_aresetn)
      accept |-> (cmd.num_accesses != '0) && (cmd.chunk_len != '0) &&
                 (cmd.mem_size != '0));

endmodule

// ==== src/mem_bench_pkg.sv ====
package mem_bench_pkg;

   // channel count and datapath widths
   localparam int NUM_CHANNELS = 2;
   localparam int ADDR_W       = 48;         // byte address and region size
   localparam int LEN_W        = 32;         // counts, chunk length, stride
   localparam int CYCLE_W      = 64;         // execution timer

   // one bit minimum so a single channel still has an index
   localparam int CHAN_IDX_W   = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [LEN_W-1:0]      len_t;
   typedef logic [CYCLE_W-1:0]    cycles_t;
   typedef logic [CHAN_IDX_W-1:0] chan_idx_t;

   // one benchmark run as handed to a channel
   typedef struct packed {
      addr_t base_addr;      // start of the tested region
      addr_t mem_size;       // region size in bytes
      len_t  num_accesses;   // requests per run
      len_t  chunk_len;      // bytes per request
      len_t  stride;         // offset step between requests
      logic  is_write;       // write port when set, read port otherwise
   } bench_cmd_t;

   // one memory command on a read or write port
   typedef struct packed {
      addr_t addr;
      len_t  len;
   } mem_req_t;

   // per channel sequencer
   typedef enum logic [1:0] {
      IDLE,    // waiting for start
      ISSUE,   // requests going out
      DRAIN    // waiting for the remaining status strobes
   } gen_state_t;

endpackage
